/* logic/ram_ctrl_pkg.sv */
//----------------------------------------------------------------------
// memory controller shared types
// word and address widths, sequencer state encoding
//----------------------------------------------------------------------

package ram_ctrl_pkg;

   // data path width, both memories
   localparam int WORD_BITS = 32;

   // full address widths as seen on the ports
   localparam int DRAM_ADDR_W = 22;
   localparam int VRAM_ADDR_W = 15;

   typedef logic [WORD_BITS-1:0]   word_t;
   typedef logic [DRAM_ADDR_W-1:0] dram_addr_t;
   typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;

   // returned for main-memory reads past the populated range
   localparam word_t all_ones_word = 32'hffffffff;

   //----------------------------------------------------------------------
   // main-memory sequencer states
   //----------------------------------------------------------------------

   // one-hot, one bit per state
   typedef enum logic [4:0] {
      sd_idle       = 5'b00001,
      sd_read       = 5'b00010,
      sd_read_wait  = 5'b00100,
      sd_write      = 5'b01000,
      sd_write_wait = 5'b10000
   } sd_state_t;

endpackage

/* logic/mem_port_if.sv */
//----------------------------------------------------------------------
// word store access bus
// single-cycle rd/wr strobes from the sequencer, registered read data back
//----------------------------------------------------------------------

interface mem_port_if
   import ram_ctrl_pkg::*;
#(
   parameter int ADDR_BITS = 17
)
();

   // offset within the populated range
   logic [ADDR_BITS-1:0] addr;
   word_t                wdata;
   word_t                rdata;

   // at most one strobe per cycle
   logic                 rd;
   logic                 wr;

   // sequencer side
   modport seq (
      output addr,
      output wdata,
      output rd,
      output wr,
      input  rdata
   );

   // store side, rdata valid the cycle after rd
   modport store (
      input  addr,
      input  wdata,
      input  rd,
      input  wr,
      output rdata
   );

endinterface

/* logic/sdram_port_seq.sv */
//----------------------------------------------------------------------
// main-memory port sequencer
// one-hot FSM turning held req/write levels into single store strobes
//----------------------------------------------------------------------

module sdram_port_seq
   import ram_ctrl_pkg::*;
#(
   parameter int DRAM_ADDR_BITS = 17
)
(
   input  logic       clk,
   input  logic       reset,

   input  dram_addr_t sdram_addr,
   input  word_t      sdram_data_in,
   input  logic       sdram_req,
   input  logic       sdram_write,
   output word_t      sdram_data_out,
   output logic       sdram_ready,
   output logic       sdram_done,

   mem_port_if.seq    mem
);

   sd_state_t state;
   sd_state_t state_next;
   logic      in_range;

   // populated only when nothing above the low bits is set
   assign in_range = (sdram_addr >> DRAM_ADDR_BITS) == '0;

   //----------------------------------------------------------------------
   // state machine
   //----------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= sd_idle;
      else
         state <= state_next;
   end

   // req has priority over write when both show up in idle
   always_comb
   begin
      state_next = state;
      case (state)
         sd_idle:
         begin
            if (sdram_req)
               state_next = sd_read;
            else if (sdram_write)
               state_next = sd_write;
         end
         sd_read:
            state_next = sd_read_wait;
         sd_read_wait:
         begin
            // master drops req once it has seen ready
            if (!sdram_req)
               state_next = sd_idle;
         end
         sd_write:
            state_next = sd_write_wait;
         sd_write_wait:
         begin
            if (!sdram_write)
               state_next = sd_idle;
         end
         default:
            state_next = sd_idle;
      endcase
   end

   //----------------------------------------------------------------------
   // store strobes
   //----------------------------------------------------------------------

   assign mem.addr  = sdram_addr[DRAM_ADDR_BITS-1:0];
   assign mem.wdata = sdram_data_in;

   // one cycle each, never for an unpopulated address
   assign mem.rd    = (state == sd_read) && in_range;
   assign mem.wr    = (state == sd_write) && in_range;

   //----------------------------------------------------------------------
   // data return and ready/done levels
   //----------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sdram_data_out <= '0;
         sdram_ready    <= 1'b0;
         sdram_done     <= 1'b0;
      end
      else
      begin
         // capture once on entry to the read wait, then hold
         if (state == sd_read_wait && !sdram_ready)
            sdram_data_out <= in_range ? mem.rdata : all_ones_word;

         // levels stay up only while the master keeps asking
         sdram_ready <= (state == sd_read_wait) && sdram_req;
         sdram_done  <= (state == sd_write_wait) && sdram_write;
      end
   end

   // state register must stay one-hot
   assert property (@(posedge clk) disable iff (reset) $onehot(state))
      else $error("sdram_port_seq: state %b is not one-hot", state);

   // store never sees a read and a write in one cycle
   assert property (@(posedge clk) disable iff (reset) !(mem.rd && mem.wr))
      else $error("sdram_port_seq: rd and wr high together");

endmodule

/* logic/dram_store.sv */
//----------------------------------------------------------------------
// main-memory word store
// stands in for the external SDRAM, registered read
//----------------------------------------------------------------------

module dram_store
   import ram_ctrl_pkg::*;
#(
   parameter int DRAM_ADDR_BITS = 17
)
(
   input  logic      clk,
   input  logic      reset,

   mem_port_if.store mem
);

   localparam int DEPTH = 1 << DRAM_ADDR_BITS;

   word_t store_mem [DEPTH];

   // powers up cleared
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         store_mem[i] = '0;
   end

   //----------------------------------------------------------------------
   // write and read ports
   //----------------------------------------------------------------------

   always @(posedge clk)
   begin
      if (mem.wr)
         store_mem[mem.addr] <= mem.wdata;
   end

   // data valid the cycle after rd, held until the next rd
   always_ff @(posedge clk)
   begin
      if (mem.rd)
         mem.rdata <= store_mem[mem.addr];
   end

   // once reset has been seen for a cycle the sequencer is parked in idle
   assert property (@(posedge clk) reset ##1 reset |-> !(mem.rd || mem.wr))
      else $error("dram_store: strobe seen during reset");

endmodule

/* logic/vram_dpram.sv */
//----------------------------------------------------------------------
// video RAM, dual port
// cpu read/write port plus an always-enabled display read port
//----------------------------------------------------------------------

module vram_dpram
   import ram_ctrl_pkg::*;
#(
   parameter int VRAM_WORDS = 21504
)
(
   input  logic       clk,
   input  logic       reset,

   // cpu side
   input  vram_addr_t cpu_addr,
   input  word_t      cpu_wdata,
   input  logic       cpu_rd,
   input  logic       cpu_wr,
   output word_t      cpu_rdata,

   // display side, read only
   input  vram_addr_t vga_addr,
   output word_t      vga_rdata
);

   word_t vram [VRAM_WORDS];
   logic  cpu_in_range;
   logic  vga_in_range;

   initial
   begin
      for (int i = 0; i < VRAM_WORDS; i++)
         vram[i] = '0;
   end

   assign cpu_in_range = int'(cpu_addr) < VRAM_WORDS;
   assign vga_in_range = int'(vga_addr) < VRAM_WORDS;

   // writes past the end are dropped
   always @(posedge clk)
   begin
      if (cpu_wr && cpu_in_range)
         vram[cpu_addr] <= cpu_wdata;
   end

   // read-before-write on a same-address collision
   always_ff @(posedge clk)
   begin
      if (reset)
         cpu_rdata <= '0;
      else if (cpu_rd)
         cpu_rdata <= cpu_in_range ? vram[cpu_addr] : '0;
   end

   // display port reads every cycle
   always_ff @(posedge clk)
   begin
      if (reset)
         vga_rdata <= '0;
      else
         vga_rdata <= vga_in_range ? vram[vga_addr] : '0;
   end

   // flag cpu writes beyond the populated depth
   assert property (@(posedge clk) disable iff (reset) cpu_wr |-> cpu_in_range)
      else $warning("vram_dpram: cpu write to %h past end, dropped", cpu_addr);

endmodule

/* logic/ram_ctrl_top.sv */
//----------------------------------------------------------------------
// memory controller top level
// main-memory port with its word store, plus the dual-port video RAM
//----------------------------------------------------------------------

module ram_ctrl_top
   import ram_ctrl_pkg::*;
#(
   parameter int DRAM_ADDR_BITS = 17,
   parameter int VRAM_WORDS     = 21504
)
(
   input  logic       clk,
   input  logic       reset,

   // main memory
   input  dram_addr_t sdram_addr,
   input  word_t      sdram_data_in,
   input  logic       sdram_req,
   input  logic       sdram_write,
   output word_t      sdram_data_out,
   output logic       sdram_ready,
   output logic       sdram_done,

   // video RAM, cpu side
   input  vram_addr_t vram_cpu_addr,
   input  word_t      vram_cpu_data_in,
   input  logic       vram_cpu_req,
   input  logic       vram_cpu_write,
   output word_t      vram_cpu_data_out,

   // video RAM, display side
   input  vram_addr_t vram_vga_addr,
   output word_t      vram_vga_data_out
);

   //----------------------------------------------------------------------
   // main memory
   //----------------------------------------------------------------------

   mem_port_if #(
      .ADDR_BITS (DRAM_ADDR_BITS)
   ) dram_bus ();

   sdram_port_seq #(
      .DRAM_ADDR_BITS (DRAM_ADDR_BITS)
   ) u_seq (
      .clk            (clk),
      .reset          (reset),
      .sdram_addr     (sdram_addr),
      .sdram_data_in  (sdram_data_in),
      .sdram_req      (sdram_req),
      .sdram_write    (sdram_write),
      .sdram_data_out (sdram_data_out),
      .sdram_ready    (sdram_ready),
      .sdram_done     (sdram_done),
      .mem            (dram_bus.seq)
   );

   dram_store #(
      .DRAM_ADDR_BITS (DRAM_ADDR_BITS)
   ) u_store (
      .clk   (clk),
      .reset (reset),
      .mem   (dram_bus.store)
   );

   //----------------------------------------------------------------------
   // video RAM
   //----------------------------------------------------------------------

   vram_dpram #(
      .VRAM_WORDS (VRAM_WORDS)
   ) u_vram (
      .clk       (clk),
      .reset     (reset),
      .cpu_addr  (vram_cpu_addr),
      .cpu_wdata (vram_cpu_data_in),
      .cpu_rd    (vram_cpu_req),
      .cpu_wr    (vram_cpu_write),
      .cpu_rdata (vram_cpu_data_out),
      .vga_addr  (vram_vga_addr),
      .vga_rdata (vram_vga_data_out)
   );

endmodule

/* tests/ram_ctrl_tb.sv */
//----------------------------------------------------------------------
// memory controller testbench
// random main-memory and video RAM traffic checked against models
//----------------------------------------------------------------------

module ram_ctrl_tb
   import ram_ctrl_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int DRAM_ADDR_BITS  = 17;
   localparam int VRAM_WORDS      = 21504;
   localparam int HANDSHAKE_LIMIT = 20;
   localparam int DRAM_OPS        = 200;
   localparam int VRAM_OPS        = 200;

   logic       clk;
   logic       reset;
   dram_addr_t sdram_addr;
   word_t      sdram_data_in;
   logic       sdram_req;
   logic       sdram_write;
   word_t      sdram_data_out;
   logic       sdram_ready;
   logic       sdram_done;
   vram_addr_t vram_cpu_addr;
   word_t      vram_cpu_data_in;
   logic       vram_cpu_req;
   logic       vram_cpu_write;
   word_t      vram_cpu_data_out;
   vram_addr_t vram_vga_addr;
   word_t      vram_vga_data_out;

   // reference contents, missing keys read as the cleared value
   word_t dram_model [int];
   word_t vram_model [int];

   int    seed;
   int    error_count;
   int    errors_before;
   int    tests_run;
   int    tests_failed;
   event  hang_seen;
   string hang_reason;

   ram_ctrl_top #(
      .DRAM_ADDR_BITS (DRAM_ADDR_BITS),
      .VRAM_WORDS     (VRAM_WORDS)
   ) DUT (.*);

   initial
      clk = 1'b0;

   always #10 clk = ~clk;

   //----------------------------------------------------------------------
   // helpers
   //----------------------------------------------------------------------

   // drive and sample point, just after the rising edge
   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   function automatic logic [31:0] next_rand();
      next_rand = $random(seed);
   endfunction

   function automatic word_t dram_peek(int off);
      if (!dram_model.exists(off))
         return '0;
      return dram_model[off];
   endfunction

   function automatic word_t vram_peek(int addr);
      if (addr >= VRAM_WORDS || !vram_model.exists(addr))
         return '0;
      return vram_model[addr];
   endfunction

   // small pool at both ends of the populated range, so addresses repeat
   function automatic dram_addr_t pool_addr();
      logic [31:0] r;
      r = next_rand();
      if (r[4])
         return dram_addr_t'(int'(r[3:0]));
      return dram_addr_t'((1 << DRAM_ADDR_BITS) - 1 - int'(r[3:0]));
   endfunction

   function automatic vram_addr_t vram_pick(bit allow_past_end);
      logic [31:0] r;
      r = next_rand();
      if (allow_past_end && r[7:6] == 2'd0)
         return vram_addr_t'(VRAM_WORDS + int'(r[23:8]) % (32768 - VRAM_WORDS));
      if (r[5])
         return vram_addr_t'(int'(r[4:0]));
      return vram_addr_t'(VRAM_WORDS - 1 - int'(r[4:0]));
   endfunction

   task automatic report_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
      $display("** Error: %s expected %h, got %h", name, exp, got);
      error_count++;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (error_count == errors_before)
         $display("test %s: PASS", name);
      else
      begin
         tests_failed++;
         $display("test %s: FAIL, %0d errors", name, error_count - errors_before);
      end
      errors_before = error_count;
   endtask

   // steps until ready (or done) shows, bounded
   task automatic wait_level(input bit for_done, output int cycles);
      cycles = 0;
      while (!(for_done ? sdram_done : sdram_ready) && cycles < HANDSHAKE_LIMIT)
      begin
         tick();
         cycles++;
      end
      if (!(for_done ? sdram_done : sdram_ready))
      begin
         hang_reason = for_done ? "timeout: sdram_done never rose on a write"
                                : "timeout: sdram_ready never rose on a read";
         -> hang_seen;
         @(posedge clk);
      end
   endtask

   // one main-memory access, level held for hold extra cycles past the handshake
   task automatic dram_access(input bit req, input bit write, input dram_addr_t addr,
                              input word_t data, input int hold);
      int    cycles;
      int    off;
      bit    in_range;
      bit    is_write;
      word_t expected;
      is_write = write && !req;
      off      = int'(addr[DRAM_ADDR_BITS-1:0]);
      in_range = (addr >> DRAM_ADDR_BITS) == '0;
      expected = in_range ? dram_peek(off) : all_ones_word;
      sdram_addr    = addr;
      sdram_data_in = data;
      sdram_req     = req;
      sdram_write   = write;
      wait_level(is_write, cycles);
      // sampled on the first edge, level two edges later
      if (cycles - 1 != 2)
         report_value(is_write ? "sdram_done latency" : "sdram_ready latency", 2, cycles - 1);
      if (is_write && in_range)
         dram_model[off] = data;
      for (int i = 0; i <= hold; i++)
      begin
         if (i > 0)
            tick();
         if ({sdram_ready, sdram_done} !== (is_write ? 2'b01 : 2'b10))
            report_value("{sdram_ready,sdram_done}", 32'(is_write ? 2'b01 : 2'b10),
                         32'({sdram_ready, sdram_done}));
         if (!is_write && sdram_data_out !== expected)
            report_value("sdram_data_out", expected, sdram_data_out);
      end
      sdram_req   = 1'b0;
      sdram_write = 1'b0;
      tick();
      if ({sdram_ready, sdram_done} !== 2'b00)
         report_value("{sdram_ready,sdram_done} after drop", 0, 32'({sdram_ready, sdram_done}));
   endtask

   // ends the run when a handshake wait gives up
   initial
   begin
      @(hang_seen);
      $display("%s", hang_reason);
      $display("tests failed");
      $finish;
   end

   //----------------------------------------------------------------------
   // test sequence
   //----------------------------------------------------------------------

   initial
   begin
      logic [31:0] r;
      dram_addr_t  a;
      vram_addr_t  va;
      vram_addr_t  vb;
      word_t       expected;
      word_t       cpu_last;
      logic [DRAM_ADDR_W-DRAM_ADDR_BITS-1:0] hi;

      seed = 32'h4c11351f;
      error_count = 0;
      errors_before = 0;
      tests_run = 0;
      tests_failed = 0;
      reset = 1'b1;
      sdram_addr = '0;
      sdram_data_in = '0;
      sdram_req = 1'b0;
      sdram_write = 1'b0;
      vram_cpu_addr = '0;
      vram_cpu_data_in = '0;
      vram_cpu_req = 1'b0;
      vram_cpu_write = 1'b0;
      vram_vga_addr = '0;
      repeat (5) tick();
      reset = 1'b0;

      if ({sdram_ready, sdram_done} !== 2'b00)
         report_value("{sdram_ready,sdram_done}", 0, 32'({sdram_ready, sdram_done}));
      if (sdram_data_out !== '0)
         report_value("sdram_data_out", 0, sdram_data_out);
      if (vram_cpu_data_out !== '0)
         report_value("vram_cpu_data_out", 0, vram_cpu_data_out);
      finish_test("reset values");

      for (int n = 0; n < DRAM_OPS; n++)
      begin
         r = next_rand();
         dram_access(r[0], !r[0], pool_addr(), next_rand(), 0);
      end
      finish_test("dram random access");

      // write an offset, then alias it from above the populated range
      for (int n = 0; n < 16; n++)
      begin
         a = pool_addr();
         r = next_rand();
         hi = r[DRAM_ADDR_W-DRAM_ADDR_BITS-1:0];
         hi[0] = 1'b1;
         dram_access(1'b0, 1'b1, a, next_rand(), 0);
         dram_access(1'b0, 1'b1, {hi, a[DRAM_ADDR_BITS-1:0]}, next_rand(), 0);
         dram_access(1'b1, 1'b0, {hi, a[DRAM_ADDR_BITS-1:0]}, '0, 0);
         dram_access(1'b1, 1'b0, a, '0, 0);
      end
      finish_test("dram out of range");

      // cpu read data holds its reset value until the first read
      cpu_last = '0;

      // read returns the old word when written in the same cycle
      for (int n = 0; n < VRAM_OPS; n++)
      begin
         r = next_rand();
         va = vram_pick(1'b1);
         vram_cpu_addr = va;
         vram_cpu_data_in = next_rand();
         vram_cpu_req = r[0];
         vram_cpu_write = r[1];
         if (r[0])
            cpu_last = vram_peek(int'(va));
         expected = cpu_last;
         if (r[1] && int'(va) < VRAM_WORDS)
            vram_model[int'(va)] = vram_cpu_data_in;
         tick();
         if (vram_cpu_data_out !== expected)
            report_value("vram_cpu_data_out", expected, vram_cpu_data_out);
      end
      vram_cpu_req = 1'b0;
      vram_cpu_write = 1'b0;
      finish_test("vram cpu port");

      for (int n = 0; n < VRAM_OPS; n++)
      begin
         va = vram_pick(1'b1);
         vb = vram_pick(1'b0);
         if (vb == va)
            vb = va ^ 15'd1;
         vram_vga_addr = va;
         vram_cpu_addr = vb;
         vram_cpu_data_in = next_rand();
         vram_cpu_write = 1'b1;
         expected = vram_peek(int'(va));
         vram_model[int'(vb)] = vram_cpu_data_in;
         tick();
         if (vram_vga_data_out !== expected)
            report_value("vram_vga_data_out", expected, vram_vga_data_out);
      end
      vram_cpu_write = 1'b0;
      finish_test("vram display port");

      for (int n = 0; n < 20; n++)
      begin
         r = next_rand();
         dram_access(r[0], !r[0], pool_addr(), next_rand(), 1 + int'(r[3:1]));
      end
      // both levels at once, only the read may happen
      a = pool_addr();
      dram_access(1'b1, 1'b1, a, next_rand(), 2);
      dram_access(1'b1, 1'b0, a, '0, 0);
      finish_test("held levels and priority");

      $display("summary: %0d run, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, error_count);
      if (tests_failed == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* flist.f */
logic/ram_ctrl_pkg.sv
logic/mem_port_if.sv
logic/sdram_port_seq.sv
logic/dram_store.sv
logic/vram_dpram.sv
logic/ram_ctrl_top.sv
tests/ram_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f flist.f --top-module ram_ctrl_tb -Mdir "$OBJ" -o ram_ctrl_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/ram_ctrl_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the testbench reports its verdict in the log
if grep -q "tests failed" "$LOG"; then
   exit 1
fi
exit 0
